// ==== compile.f ====
+incdir+design
design/peripheral_pkg.sv
design/io_decoder.sv
design/ems_mapper.sv
design/port_registers.sv
design/bus_read_mux.sv
design/xt_peripherals.sv
testbench/bus_checker.sv
testbench/tb_xt_peripherals.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_xt_peripherals
FILELIST  ?= compile.f

OBJDIR := obj_dir
LOG    := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG) and check it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== testbench/tb_xt_peripherals.sv ====
/*
 * Testbench for the XT peripheral glue
 * LFSR-driven bus cycles, compared by bus_checker
 */

`timescale 1ns/10ps
`default_nettype none

`include "peripheral_cfg.svh"

module tb_xt_peripherals;

    import peripheral_pkg::*;

    localparam int READ_TIMEOUT = 8;

    logic          clock;
    logic          reset;
    bus_addr_t     address_i;
    byte_t         data_i;
    logic          io_read_n_i;
    logic          io_write_n_i;
    logic          memory_read_n_i;
    logic          memory_write_n_i;
    logic          aen_n_i;
    logic          ems_enable_i;
    ems_base_sel_t ems_base_i;
    logic          tandy_mode_i;
    logic          dma_cs_n_o;
    logic          dma_page_cs_n_o;
    logic [3:0]    ems_window_o;
    byte_t         data_o;
    logic          data_valid_o;
    logic [15:0]   lfsr_state = 16'd10732;

    xt_peripherals i_dut (.*);

    bus_checker i_checker (
        .*,
        .dma_cs_n_i      (dma_cs_n_o),
        .dma_page_cs_n_i (dma_page_cs_n_o),
        .ems_window_i    (ems_window_o),
        .read_data_i     (data_o),
        .read_valid_i    (data_valid_o)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Feedback polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [19:0] random_bits(input int count);
        logic [19:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value      = {value[18:0], feedback};
        end
        return value;
    endfunction

    // Three write edges, then idle while the EMS entry settles
    task automatic io_write(input io_addr_t port, input byte_t value);
        address_i    <= {4'h0, port};
        data_i       <= value;
        io_write_n_i <= 1'b0;
        repeat (3) @(posedge clock);
        io_write_n_i <= 1'b1;
        repeat (3) @(posedge clock);
    endtask

    task automatic io_read(input io_addr_t port, input logic response);
        int   waited;
        logic seen;
        waited      = 0;
        seen        = 1'b0;
        address_i   <= {4'h0, port};
        io_read_n_i <= 1'b0;
        if (response) begin
            while (!seen && waited < READ_TIMEOUT) begin
                @(negedge clock);
                waited++;
                seen = data_valid_o;
            end
            if (!seen) begin
                i_checker.report_failure(
                    $sformatf("timeout, no read response from port %h", port));
            end
        end else begin
            repeat (2) @(negedge clock);
        end
        @(posedge clock);
        io_read_n_i <= 1'b1;
        @(posedge clock);
    endtask

    // levels holds aen_n, io_write_n and io_read_n
    task automatic decode_cycle(input io_addr_t port, input logic [2:0] levels);
        address_i    <= {4'h0, port};
        io_read_n_i  <= levels[0];
        io_write_n_i <= levels[1];
        aen_n_i      <= levels[2];
        @(posedge clock);
        io_read_n_i  <= 1'b1;
        io_write_n_i <= 1'b1;
        aen_n_i      <= 1'b0;
        @(posedge clock);
    endtask

    task automatic memory_access(input bus_addr_t addr, input logic write);
        address_i        <= addr;
        memory_read_n_i  <= write;
        memory_write_n_i <= ~write;
        @(posedge clock);
        memory_read_n_i  <= 1'b1;
        memory_write_n_i <= 1'b1;
        @(posedge clock);
    endtask

    initial begin
        io_addr_t   port;
        bus_addr_t  mem_addr;
        byte_t      value;
        logic [1:0] kind;
        reset            <= 1'b1;
        address_i        <= '0;
        data_i           <= '0;
        io_read_n_i      <= 1'b1;
        io_write_n_i     <= 1'b1;
        memory_read_n_i  <= 1'b1;
        memory_write_n_i <= 1'b1;
        aen_n_i          <= 1'b0;
        ems_enable_i     <= 1'b1;
        ems_base_i       <= 2'b00;
        tandy_mode_i     <= 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        i_checker.start_test("reset_values");
        io_read(`LPT_PORT, 1'b1);
        io_read(`NMI_MASK_BASE, 1'b1);
        memory_access(20'hA0000, 1'b0);
        i_checker.finish_test();

        i_checker.start_test("dma_decode");
        repeat (200) begin
            port = io_addr_t'(random_bits(16));
            if (random_bits(1) != '0) begin
                port[9:8] = 2'b00;
            end
            decode_cycle(port, 3'(random_bits(3)));
        end
        i_checker.finish_test();

        i_checker.start_test("ems_mapping");
        repeat (40) begin
            kind  = 2'(random_bits(2));
            value = byte_t'(random_bits(8));
            value = kind == 2'd0 ? `EMS_DISABLE_CODE : kind == 2'd1 ? {1'b0, value[6:0]} : value;
            io_write(`EMS_PORT_BASE + io_addr_t'(random_bits(2)), value);
            io_read(`EMS_PORT_BASE + io_addr_t'(random_bits(2)), 1'b1);
        end
        ems_enable_i <= 1'b0;
        @(posedge clock);
        io_read(`EMS_PORT_BASE + io_addr_t'(random_bits(2)), 1'b0);
        ems_enable_i <= 1'b1;
        @(posedge clock);
        i_checker.finish_test();

        i_checker.start_test("ems_window");
        for (int slot = 0; slot < 4; slot++) begin
            io_write(`EMS_PORT_BASE + io_addr_t'(slot), byte_t'(random_bits(7)));
        end
        io_write(`EMS_PORT_BASE + io_addr_t'(random_bits(2)), `EMS_DISABLE_CODE);
        repeat (100) begin
            ems_base_i <= ems_base_sel_t'(random_bits(2));
            mem_addr   = random_bits(20);
            kind       = 2'(random_bits(2));
            mem_addr[19:16] = kind == 2'd0 ? `EMS_WIN_A : kind == 2'd1 ? `EMS_WIN_C :
                kind == 2'd2 ? `EMS_WIN_D : mem_addr[19:16];
            memory_access(mem_addr, random_bits(1) != '0);
        end
        i_checker.finish_test();

        i_checker.start_test("port_registers");
        repeat (20) begin
            tandy_mode_i <= random_bits(1) != '0;
            port = `NMI_MASK_BASE + io_addr_t'(random_bits(3));
            io_write(`LPT_PORT, byte_t'(random_bits(8)));
            io_write(port, byte_t'(random_bits(8)));
            io_read(`LPT_PORT, 1'b1);
            io_read(port, tandy_mode_i);
            io_read(16'h02F8 + io_addr_t'(random_bits(3)), 1'b0);
            // Mask value seen again in Tandy mode
            tandy_mode_i <= 1'b1;
            io_read(port, 1'b1);
        end
        i_checker.finish_test();

        $display("Tests: %0d, checks: %0d, errors: %0d",
                 i_checker.tests_run, i_checker.total_checks, i_checker.total_errors);
        if (i_checker.total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/bus_checker.sv ====
/*
 * Bus checker for the XT peripheral glue
 * Reference model of decode, EMS slots and port registers, compared at the DUT ports
 */

`timescale 1ns/10ps
`default_nettype none

`include "peripheral_cfg.svh"

module bus_checker (
    input wire                                clock,
    input wire                                reset,
    input wire peripheral_pkg::bus_addr_t     address_i,
    input wire peripheral_pkg::byte_t         data_i,
    input wire                                io_read_n_i,
    input wire                                io_write_n_i,
    input wire                                memory_read_n_i,
    input wire                                memory_write_n_i,
    input wire                                aen_n_i,
    input wire                                ems_enable_i,
    input wire peripheral_pkg::ems_base_sel_t ems_base_i,
    input wire                                tandy_mode_i,
    input wire                                dma_cs_n_i,
    input wire                                dma_page_cs_n_i,
    input wire [3:0]                          ems_window_i,
    input wire peripheral_pkg::byte_t         read_data_i,
    input wire                                read_valid_i
);

    import peripheral_pkg::*;

    string      test_name = "setup";
    int         test_checks = 0;
    int         test_errors = 0;
    int         total_checks = 0;
    int         total_errors = 0;
    int         tests_run = 0;

    ems_page_t  slot_page [4];
    logic [3:0] slot_enabled;
    logic       pending;
    ems_slot_t  pending_slot;
    ems_page_t  pending_page;
    logic       pending_enable;
    byte_t      lpt_value;
    byte_t      nmi_value;
    byte_t      expected_data;
    logic       expected_valid;
    logic [3:0] nibble;
    logic [3:0] window;

    io_addr_t   port;
    logic       io_cycle;
    logic       memory_cycle;
    logic       ems_hit;
    logic       lpt_hit;
    logic       nmi_hit;
    logic       dma_hit;
    logic       page_hit;

    assign port         = address_i[15:0];
    assign io_cycle     = (!io_read_n_i || !io_write_n_i) && !aen_n_i;
    assign memory_cycle = (!memory_read_n_i || !memory_write_n_i) && io_read_n_i && io_write_n_i;
    assign ems_hit  = io_cycle && ems_enable_i
        && port >= `EMS_PORT_BASE && port <= `EMS_PORT_BASE + 16'd3;
    assign lpt_hit  = io_cycle && port == `LPT_PORT;
    assign nmi_hit  = io_cycle && tandy_mode_i
        && port >= `NMI_MASK_BASE && port <= `NMI_MASK_BASE + 16'd7;
    // Only the low ten port bits take part in the XT decode
    assign dma_hit  = io_cycle && port[9:0] <= 10'h01F;
    assign page_hit = io_cycle && port[9:0] >= 10'h080 && port[9:0] <= 10'h09F;

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("Test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic report_failure(input string what);
        $display("ERROR in %s: %s", test_name, what);
        test_errors++;
        total_errors++;
    endtask

    task automatic check_value(input string what, input logic [7:0] expected,
                               input logic [7:0] actual);
        test_checks++;
        total_checks++;
        if (actual !== expected) begin
            $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
            test_errors++;
            total_errors++;
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            slot_enabled   = '0;
            pending        = 1'b0;
            lpt_value      = `PORT_RESET_VALUE;
            nmi_value      = `PORT_RESET_VALUE;
            expected_data  = '0;
            expected_valid = 1'b0;
            for (int i = 0; i < 4; i++) begin
                slot_page[i] = '0;
            end
        end else begin
            // Read result uses the state from before this edge
            expected_valid = !io_read_n_i && (ems_hit || lpt_hit || nmi_hit);
            expected_data  = 8'h00;
            if (!io_read_n_i && ems_hit) begin
                expected_data = slot_enabled[port[1:0]] ?
                    {1'b0, slot_page[port[1:0]]} : `EMS_DISABLE_CODE;
            end else if (!io_read_n_i && lpt_hit) begin
                expected_data = lpt_value;
            end else if (!io_read_n_i && nmi_hit) begin
                expected_data = nmi_value;
            end
            // An EMS entry written at one edge lands at the next
            if (pending) begin
                slot_page[pending_slot]    = pending_page;
                slot_enabled[pending_slot] = pending_enable;
            end
            pending        = !io_write_n_i && ems_hit
                && (data_i == `EMS_DISABLE_CODE || data_i < `EMS_MAP_LIMIT);
            pending_slot   = port[1:0];
            pending_enable = data_i != `EMS_DISABLE_CODE;
            pending_page   = pending_enable ? data_i[6:0] : 7'h7F;
            if (!io_write_n_i && lpt_hit) begin
                lpt_value = data_i;
            end
            if (!io_write_n_i && nmi_hit) begin
                nmi_value = data_i;
            end
        end
    end

    always @(negedge clock) begin
        if (!reset) begin
            nibble = ems_base_i == 2'b00 ? `EMS_WIN_A : ems_base_i == 2'b01 ? `EMS_WIN_C : `EMS_WIN_D;
            for (int n = 0; n < 4; n++) begin
                window[n] = memory_cycle && slot_enabled[n]
                    && address_i[19:16] == nibble && address_i[15:14] == n[1:0];
            end
            check_value("dma_cs_n", {7'b0, !dma_hit}, {7'b0, dma_cs_n_i});
            check_value("dma_page_cs_n", {7'b0, !page_hit}, {7'b0, dma_page_cs_n_i});
            check_value("ems_window", {4'b0, window}, {4'b0, ems_window_i});
            check_value("data_valid", {7'b0, expected_valid}, {7'b0, read_valid_i});
            check_value("data", expected_data, read_data_i);
        end
    end

endmodule

`default_nettype wire

// ==== design/xt_peripherals.sv ====
/*
 * XT peripheral glue top level
 * I/O decoding, EMS mapper, port registers and bus read path
 */

`timescale 1ns/10ps
`default_nettype none

module xt_peripherals (
    input  wire                                clock,
    input  wire                                reset,
    input  wire peripheral_pkg::bus_addr_t     address_i,
    input  wire peripheral_pkg::byte_t         data_i,
    input  wire                                io_read_n_i,
    input  wire                                io_write_n_i,
    input  wire                                memory_read_n_i,
    input  wire                                memory_write_n_i,
    input  wire                                aen_n_i,
    input  wire                                ems_enable_i,
    input  wire peripheral_pkg::ems_base_sel_t ems_base_i,
    input  wire                                tandy_mode_i,
    output logic                               dma_cs_n_o,
    output logic                               dma_page_cs_n_o,
    output logic [3:0]                         ems_window_o,
    output peripheral_pkg::byte_t              data_o,
    output logic                               data_valid_o
);

    import peripheral_pkg::*;

    logic  ems_sel;
    logic  lpt_sel;
    logic  nmi_sel;
    byte_t ems_read_data;
    byte_t lpt_data;
    byte_t nmi_data;

    io_decoder i_io_decoder (
        .address_i       (address_i),
        .io_read_n_i     (io_read_n_i),
        .io_write_n_i    (io_write_n_i),
        .aen_n_i         (aen_n_i),
        .ems_enable_i    (ems_enable_i),
        .tandy_mode_i    (tandy_mode_i),
        .dma_cs_n_o      (dma_cs_n_o),
        .dma_page_cs_n_o (dma_page_cs_n_o),
        .ems_sel_o       (ems_sel),
        .lpt_sel_o       (lpt_sel),
        .nmi_sel_o       (nmi_sel)
    );

    ems_mapper i_ems_mapper (
        .clock            (clock),
        .reset            (reset),
        .address_i        (address_i),
        .data_i           (data_i),
        .io_write_n_i     (io_write_n_i),
        .io_read_n_i      (io_read_n_i),
        .memory_read_n_i  (memory_read_n_i),
        .memory_write_n_i (memory_write_n_i),
        .ems_sel_i        (ems_sel),
        .ems_base_i       (ems_base_i),
        .read_data_o      (ems_read_data),
        .ems_window_o     (ems_window_o)
    );

    port_registers i_port_registers (
        .clock        (clock),
        .reset        (reset),
        .data_i       (data_i),
        .io_write_n_i (io_write_n_i),
        .lpt_sel_i    (lpt_sel),
        .nmi_sel_i    (nmi_sel),
        .lpt_data_o   (lpt_data),
        .nmi_data_o   (nmi_data)
    );

    bus_read_mux i_bus_read_mux (
        .clock        (clock),
        .reset        (reset),
        .io_read_n_i  (io_read_n_i),
        .ems_sel_i    (ems_sel),
        .lpt_sel_i    (lpt_sel),
        .nmi_sel_i    (nmi_sel),
        .ems_data_i   (ems_read_data),
        .lpt_data_i   (lpt_data),
        .nmi_data_i   (nmi_data),
        .data_o       (data_o),
        .data_valid_o (data_valid_o)
    );

endmodule

`default_nettype wire

// ==== design/bus_read_mux.sv ====
/*
 * Read data multiplexer
 * Registered read data with a flag for when the chipset drives the bus
 */

`timescale 1ns/10ps
`default_nettype none

module bus_read_mux (
    input  wire                        clock,
    input  wire                        reset,
    input  wire                        io_read_n_i,
    input  wire                        ems_sel_i,
    input  wire                        lpt_sel_i,
    input  wire                        nmi_sel_i,
    input  wire peripheral_pkg::byte_t ems_data_i,
    input  wire peripheral_pkg::byte_t lpt_data_i,
    input  wire peripheral_pkg::byte_t nmi_data_i,
    output peripheral_pkg::byte_t      data_o,
    output logic                       data_valid_o
);

    logic io_read;

    // Selects are high on writes as well
    assign io_read = ~io_read_n_i;

    // Priority EMS, LPT, NMI mask
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_o       <= '0;
            data_valid_o <= 1'b0;
        end else if (io_read & ems_sel_i) begin
            data_o       <= ems_data_i;
            data_valid_o <= 1'b1;
        end else if (io_read & lpt_sel_i) begin
            data_o       <= lpt_data_i;
            data_valid_o <= 1'b1;
        end else if (io_read & nmi_sel_i) begin
            data_o       <= nmi_data_i;
            data_valid_o <= 1'b1;
        end else begin
            // Bus left to other devices
            data_o       <= '0;
            data_valid_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/port_registers.sv ====
/*
 * Port registers
 * Parallel-port latch at 378h and Tandy NMI mask register
 */

`timescale 1ns/10ps
`default_nettype none

`include "peripheral_cfg.svh"

module port_registers (
    input  wire                        clock,
    input  wire                        reset,
    input  wire peripheral_pkg::byte_t data_i,
    input  wire                        io_write_n_i,
    input  wire                        lpt_sel_i,
    input  wire                        nmi_sel_i,
    output peripheral_pkg::byte_t      lpt_data_o,
    output peripheral_pkg::byte_t      nmi_data_o
);

    logic lpt_write;
    logic nmi_write;

    // Loads on every edge while the write level is held
    assign lpt_write = lpt_sel_i & ~io_write_n_i;
    assign nmi_write = nmi_sel_i & ~io_write_n_i;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data_o <= `PORT_RESET_VALUE;
        end else if (lpt_write) begin
            lpt_data_o <= data_i;
        end
    end

    // Kept as a plain readable register, no paging here
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            nmi_data_o <= `PORT_RESET_VALUE;
        end else if (nmi_write) begin
            nmi_data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/ems_mapper.sv ====
/*
 * EMS page mapper
 * Four mapping registers written through a two-stage pipeline,
 * read-back value and 16 KB window hits for memory cycles
 */

`timescale 1ns/10ps
`default_nettype none

`include "peripheral_cfg.svh"

module ems_mapper (
    input  wire                                clock,
    input  wire                                reset,
    input  wire peripheral_pkg::bus_addr_t     address_i,
    input  wire peripheral_pkg::byte_t         data_i,
    input  wire                                io_write_n_i,
    input  wire                                io_read_n_i,
    input  wire                                memory_read_n_i,
    input  wire                                memory_write_n_i,
    input  wire                                ems_sel_i,
    input  wire peripheral_pkg::ems_base_sel_t ems_base_i,
    output peripheral_pkg::byte_t              read_data_o,
    output logic [3:0]                         ems_window_o
);

    import peripheral_pkg::*;

    ems_page_t  page_q [4];
    logic [3:0] enable_q;

    ems_slot_t  slot;
    logic       code_disable;
    logic       code_map;
    logic       write_hit;

    ems_slot_t  wr_slot_q;
    ems_page_t  wr_page_q;
    logic       wr_enable_q;
    logic       wr_valid_q;

    logic [3:0] base_nibble;
    logic       memory_cycle;

    assign slot         = address_i[1:0];
    assign code_disable = (data_i == `EMS_DISABLE_CODE);
    assign code_map     = (data_i < `EMS_MAP_LIMIT);

    // Codes 80h..FEh leave the slot alone
    assign write_hit = ems_sel_i & ~io_write_n_i & (code_disable | code_map);

    // First stage captures slot and new entry
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_valid_q <= 1'b0;
        end else begin
            wr_valid_q <= write_hit;
        end
    end

    always_ff @(posedge clock) begin
        wr_slot_q   <= slot;
        // FFh carries page 7Fh in its low bits
        wr_page_q   <= data_i[6:0];
        wr_enable_q <= ~code_disable;
    end

    // Second stage updates the entry
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            enable_q <= '0;
            for (int i = 0; i < 4; i++) begin
                page_q[i] <= '0;
            end
        end else if (wr_valid_q) begin
            page_q[wr_slot_q]   <= wr_page_q;
            enable_q[wr_slot_q] <= wr_enable_q;
        end
    end

    assign read_data_o = enable_q[slot] ? {1'b0, page_q[slot]} : `EMS_DISABLE_CODE;

    always_comb begin
        case (ems_base_i)
            2'b00:   base_nibble = `EMS_WIN_A;
            2'b01:   base_nibble = `EMS_WIN_C;
            default: base_nibble = `EMS_WIN_D;
        endcase
    end

    assign memory_cycle = (~memory_read_n_i | ~memory_write_n_i) & io_read_n_i & io_write_n_i;

    // Slot n covers base + n * 16 KB
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            ems_window_o[n] = memory_cycle & enable_q[n]
                & (address_i[19:14] == {base_nibble, ems_slot_t'(n)});
        end
    end

endmodule

`default_nettype wire

// ==== design/io_decoder.sv ====
/*
 * I/O address decoder
 * Chip selects for DMA and page register, selects for EMS, LPT and NMI mask
 */

`timescale 1ns/10ps
`default_nettype none

`include "peripheral_cfg.svh"

module io_decoder (
    input  wire peripheral_pkg::bus_addr_t address_i,
    input  wire                            io_read_n_i,
    input  wire                            io_write_n_i,
    input  wire                            aen_n_i,
    input  wire                            ems_enable_i,
    input  wire                            tandy_mode_i,
    output logic                           dma_cs_n_o,
    output logic                           dma_page_cs_n_o,
    output logic                           ems_sel_o,
    output logic                           lpt_sel_o,
    output logic                           nmi_sel_o
);

    import peripheral_pkg::*;

    io_addr_t   io_address;
    logic       io_cycle;
    logic       low_kb;
    logic [2:0] block;

    assign io_address = address_i[15:0];

    // CPU owns the bus and drives an I/O strobe
    assign io_cycle = (~io_read_n_i | ~io_write_n_i) & ~aen_n_i;

    // 10-bit XT decode, upper port bits are don't care here
    assign low_kb = ~io_address[9] & ~io_address[8];
    assign block  = io_address[7:5];

    assign dma_cs_n_o      = ~(io_cycle & low_kb & (block == `DMA_BLOCK));
    assign dma_page_cs_n_o = ~(io_cycle & low_kb & (block == `DMA_PAGE_BLOCK));

    // 260h..263h
    assign ems_sel_o = io_cycle & ems_enable_i
        & ({io_address[15:2], 2'b00} == `EMS_PORT_BASE);

    assign lpt_sel_o = io_cycle & (io_address == `LPT_PORT);

    // A0h..A7h, Tandy only
    assign nmi_sel_o = io_cycle & tandy_mode_i
        & ({io_address[15:3], 3'b000} == `NMI_MASK_BASE);

endmodule

`default_nettype wire

// ==== design/peripheral_pkg.sv ====
/*
 * XT peripheral glue types
 * Bus and register vector types shared across the block
 */

`default_nettype none

package peripheral_pkg;

    // CPU address bus
    typedef logic [19:0] bus_addr_t;

    // I/O port address, low half of the bus
    typedef logic [15:0] io_addr_t;

    typedef logic [7:0] byte_t;

    // Physical EMS page held by one mapping register
    typedef logic [6:0] ems_page_t;

    // One of the four mapping registers
    typedef logic [1:0] ems_slot_t;

    // 00 selects A0000h, 01 C0000h, anything else D0000h
    typedef logic [1:0] ems_base_sel_t;

endpackage

`default_nettype wire

// ==== design/peripheral_cfg.svh ====
/*
 * XT peripheral glue constants
 * Port addresses, EMS window bases and register reset values
 */

`ifndef PERIPHERAL_CFG_SVH
`define PERIPHERAL_CFG_SVH

// 32-port blocks in the low 1 KB of I/O space
`define DMA_BLOCK           3'd0
`define DMA_PAGE_BLOCK      3'd4

`define EMS_PORT_BASE       16'h0260
`define LPT_PORT            16'h0378
// Decoded over 8 ports
`define NMI_MASK_BASE       16'h00A0

// EMS window base nibbles, address bits 19:16
`define EMS_WIN_A           4'hA
`define EMS_WIN_C           4'hC
`define EMS_WIN_D           4'hD

`define EMS_DISABLE_CODE    8'hFF
`define EMS_MAP_LIMIT       8'h80
`define PORT_RESET_VALUE    8'hFF

`endif
